//--- logic/uart_pkg.sv
package uart_pkg;

  // **************************************************************************
  // Frame format
  // **************************************************************************

  localparam int CMD_W      = 16;  // Write flag, 7-bit address, data byte.
  localparam int DATA_W     = 8;
  localparam int FRAME_BITS = 11;  // Start, 8 data, parity, stop.

  // **************************************************************************
  // Timing, in bit times unless noted
  // **************************************************************************

  localparam int GAP_BITS          = 2;    // Idle between address and data frame.
  localparam int RESP_TIMEOUT_BITS = 40;
  localparam int CLKS_PER_BIT_DEF  = 434;  // 50 MHz at 115200 baud.

  typedef enum logic [1:0] {
    RD_OK         = 2'd0,
    RD_PARITY_ERR = 2'd1,
    RD_FRAME_ERR  = 2'd2,
    RD_TIMEOUT    = 2'd3
  } rd_status_e;

  typedef enum logic [2:0] {
    IDLE   = 3'd0,
    W_ADDR = 3'd1,
    W_GAP  = 3'd2,
    W_DATA = 3'd3,
    R_ADDR = 3'd4,
    R_WAIT = 3'd5,
    R_RECV = 3'd6
  } ctrl_state_e;

endpackage

//--- logic/uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
  parameter int clks_per_bit = uart_pkg::CLKS_PER_BIT_DEF
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        tx_start,
  input  logic [uart_pkg::DATA_W-1:0] tx_byte,
  output logic                        tx,
  output logic                        tx_busy
);

  import uart_pkg::*;

  localparam int CNT_W = $clog2(clks_per_bit);

  logic [CNT_W-1:0]  bit_cnt;
  logic [3:0]        bit_idx;
  logic [DATA_W+1:0] shift_q;  // Stop, parity, data.
  logic              bit_end;

  assign bit_end = (bit_cnt == CNT_W'(clks_per_bit - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx      <= 1'b1;
      tx_busy <= 1'b0;
      bit_cnt <= '0;
      bit_idx <= '0;
    end
    else if (tx_start)
    begin
      tx      <= 1'b0;  // Start bit.
      tx_busy <= 1'b1;
      bit_cnt <= '0;
      bit_idx <= '0;
    end
    else if (tx_busy)
    begin
      if (bit_end)
      begin
        bit_cnt <= '0;
        if (bit_idx == 4'(FRAME_BITS - 1))
        begin
          tx      <= 1'b1;  // Back to idle after the stop bit.
          tx_busy <= 1'b0;
        end
        else
        begin
          tx      <= shift_q[0];
          bit_idx <= bit_idx + 4'd1;
        end
      end
      else
        bit_cnt <= bit_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (tx_start)
      shift_q <= {1'b1, ^tx_byte, tx_byte};  // Even parity.
    else if (tx_busy && bit_end)
      shift_q <= shift_q >> 1;
  end

  // The controller only launches a frame once the previous one is out.
  a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
    tx_start |-> !tx_busy)
    else $error("tx_start while a frame is still being sent.");

endmodule

//--- logic/uart_rx.sv
`timescale 1ns/1ps

module uart_rx #(
  parameter int clks_per_bit = uart_pkg::CLKS_PER_BIT_DEF
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        rx,
  output logic                        rx_start_seen,
  output logic                        rx_done,
  output logic [uart_pkg::DATA_W-1:0] rx_byte,
  output uart_pkg::rd_status_e        rx_status
);

  import uart_pkg::*;

  localparam int CNT_W = $clog2(clks_per_bit);
  localparam int HALF  = clks_per_bit / 2;

  logic              rx_meta;
  logic              rx_sync;
  logic              rx_prev;
  logic              active;
  logic [CNT_W-1:0]  cnt;
  logic [3:0]        idx;
  logic              bit_end;
  logic [DATA_W-1:0] shift_q;
  logic              par_bit;
  logic              stop_bit;

  // Start check and the closing tail run on half bits, the rest on full bits.
  assign bit_end = (idx == 4'd0 || idx == 4'(FRAME_BITS)) ?
                   (cnt == CNT_W'(HALF - 1)) : (cnt == CNT_W'(clks_per_bit - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta       <= 1'b1;
      rx_sync       <= 1'b1;
      rx_prev       <= 1'b1;
      active        <= 1'b0;
      cnt           <= '0;
      idx           <= '0;
      rx_start_seen <= 1'b0;
      rx_done       <= 1'b0;
    end
    else
    begin
      rx_meta       <= rx;
      rx_sync       <= rx_meta;
      rx_prev       <= rx_sync;
      rx_start_seen <= 1'b0;
      rx_done       <= 1'b0;
      if (!active)
      begin
        cnt <= '0;
        idx <= '0;
        if (rx_prev && !rx_sync)
          active <= 1'b1;  // Falling edge, candidate start bit.
      end
      else if (bit_end)
      begin
        cnt <= '0;
        if (idx == 4'd0)
        begin
          if (!rx_sync)
          begin
            idx           <= 4'd1;
            rx_start_seen <= 1'b1;
          end
          else
            active <= 1'b0;  // Glitch.
        end
        else if (idx == 4'(FRAME_BITS))
        begin
          active  <= 1'b0;
          rx_done <= 1'b1;
        end
        else
          idx <= idx + 4'd1;
      end
      else
        cnt <= cnt + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (active && bit_end)
    begin
      if (idx >= 4'd1 && idx <= 4'd8)
        shift_q <= {rx_sync, shift_q[DATA_W-1:1]};  // LSB first.
      else if (idx == 4'd9)
        par_bit <= rx_sync;
      else if (idx == 4'd10)
        stop_bit <= rx_sync;
      else if (idx == 4'(FRAME_BITS))
      begin
        rx_byte <= shift_q;
        if (!stop_bit)
          rx_status <= RD_FRAME_ERR;
        else if (par_bit != ^shift_q)
          rx_status <= RD_PARITY_ERR;
        else
          rx_status <= RD_OK;
      end
    end
  end

endmodule

//--- logic/uart_cmd_ctrl.sv
`timescale 1ns/1ps

module uart_cmd_ctrl #(
  parameter int clks_per_bit = uart_pkg::CLKS_PER_BIT_DEF
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [uart_pkg::CMD_W-1:0]  cmd_in,
  input  logic                        cmd_vld,
  output logic                        cmd_rdy,
  output logic                        tx_start,
  output logic [uart_pkg::DATA_W-1:0] tx_byte,
  input  logic                        tx_busy,
  input  logic                        rx_start_seen,
  input  logic                        rx_done,
  input  logic [uart_pkg::DATA_W-1:0] rx_byte,
  input  uart_pkg::rd_status_e        rx_status,
  output logic                        read_vld,
  output logic [uart_pkg::DATA_W-1:0] read_data,
  output uart_pkg::rd_status_e        read_status
);

  import uart_pkg::*;

  localparam int TMR_W = $clog2(RESP_TIMEOUT_BITS * clks_per_bit);
  // Loads absorb the two cycles of frame end detection and the tx_start cycle.
  localparam int GAP_LOAD  = GAP_BITS * clks_per_bit - 4;
  localparam int WAIT_LOAD = RESP_TIMEOUT_BITS * clks_per_bit - 3;

  ctrl_state_e      state;
  ctrl_state_e      state_nxt;
  logic [CMD_W-1:0] cmd_buf;
  logic [TMR_W-1:0] tmr;
  logic             tx_busy_q;
  logic             tx_end_q;
  logic             accept;
  logic             gap_end;
  logic             resp_timeout;
  logic             resp_done;

  assign accept       = cmd_vld && cmd_rdy;
  assign gap_end      = (state == W_GAP) && (tmr == '0);
  assign resp_timeout = (state == R_WAIT) && !rx_start_seen && (tmr == '0);
  assign resp_done    = (state == R_RECV) && !read_vld && rx_done;

  // **************************************************************************
  // Next state
  // **************************************************************************

  always_comb
  begin
    state_nxt = state;
    case (state)
      IDLE:
        if (accept)
          state_nxt = cmd_in[CMD_W-1] ? W_ADDR : R_ADDR;
      W_ADDR:
        if (tx_end_q)
          state_nxt = W_GAP;
      W_GAP:
        if (gap_end)
          state_nxt = W_DATA;
      W_DATA:
        if (tx_end_q)
          state_nxt = IDLE;
      R_ADDR:
        if (tx_end_q)
          state_nxt = R_WAIT;
      R_WAIT:
        if (rx_start_seen || resp_timeout)
          state_nxt = R_RECV;
      R_RECV:
        if (read_vld)
          state_nxt = IDLE;  // Result is out, one cycle later ready again.
      default:
        state_nxt = IDLE;
    endcase
  end

  // **************************************************************************
  // Control registers
  // **************************************************************************

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= IDLE;
      cmd_rdy   <= 1'b1;
      tx_start  <= 1'b0;
      read_vld  <= 1'b0;
      tx_busy_q <= 1'b0;
      tx_end_q  <= 1'b0;
      tmr       <= '0;
    end
    else
    begin
      state     <= state_nxt;
      cmd_rdy   <= (state_nxt == IDLE);
      tx_start  <= accept || gap_end;
      read_vld  <= resp_done || resp_timeout;
      tx_busy_q <= tx_busy;
      tx_end_q  <= tx_busy_q && !tx_busy;  // Frame finished a cycle ago.
      if (state == W_ADDR && tx_end_q)
        tmr <= TMR_W'(GAP_LOAD);
      else if (state == R_ADDR && tx_end_q)
        tmr <= TMR_W'(WAIT_LOAD);
      else if ((state == W_GAP || state == R_WAIT) && tmr != '0)
        tmr <= tmr - 1'b1;
    end
  end

  // **************************************************************************
  // Payload
  // **************************************************************************

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cmd_buf <= cmd_in;
      tx_byte <= cmd_in[CMD_W-1 -: DATA_W];  // Write flag lands on bit 7.
    end
    else if (gap_end)
      tx_byte <= cmd_buf[DATA_W-1:0];
    if (resp_done)
    begin
      read_data   <= rx_byte;
      read_status <= rx_status;
    end
    else if (resp_timeout)
    begin
      read_data   <= '0;
      read_status <= RD_TIMEOUT;
    end
  end

  // A new command is only offered once the transmitter is quiet.
  a_rdy_tx_idle: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_rdy |-> !tx_busy)
    else $error("cmd_rdy high while a frame is still being sent.");

endmodule

//--- logic/uart_host_bridge.sv
`timescale 1ns/1ps

module uart_host_bridge #(
  parameter int clks_per_bit = uart_pkg::CLKS_PER_BIT_DEF
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [uart_pkg::CMD_W-1:0]  cmd_in,
  input  logic                        cmd_vld,
  output logic                        cmd_rdy,
  input  logic                        rx,
  output logic                        tx,
  output logic                        read_vld,
  output logic [uart_pkg::DATA_W-1:0] read_data,
  output uart_pkg::rd_status_e        read_status
);

  import uart_pkg::*;

  logic              tx_start;
  logic [DATA_W-1:0] tx_byte;
  logic              tx_busy;
  logic              rx_start_seen;
  logic              rx_done;
  logic [DATA_W-1:0] rx_byte;
  rd_status_e        rx_status;

  uart_cmd_ctrl #(
    .clks_per_bit (clks_per_bit)
  ) i_uart_cmd_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd_in        (cmd_in),
    .cmd_vld       (cmd_vld),
    .cmd_rdy       (cmd_rdy),
    .tx_start      (tx_start),
    .tx_byte       (tx_byte),
    .tx_busy       (tx_busy),
    .rx_start_seen (rx_start_seen),
    .rx_done       (rx_done),
    .rx_byte       (rx_byte),
    .rx_status     (rx_status),
    .read_vld      (read_vld),
    .read_data     (read_data),
    .read_status   (read_status)
  );

  uart_tx #(
    .clks_per_bit (clks_per_bit)
  ) i_uart_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_busy  (tx_busy)
  );

  uart_rx #(
    .clks_per_bit (clks_per_bit)
  ) i_uart_rx (
    .clk           (clk),
    .rst_n         (rst_n),
    .rx            (rx),
    .rx_start_seen (rx_start_seen),
    .rx_done       (rx_done),
    .rx_byte       (rx_byte),
    .rx_status     (rx_status)
  );

endmodule

//--- test/uart_dev_model.sv
`timescale 1ns/1ps

module uart_dev_model #(
  parameter int clks_per_bit = 16
) (
  input  logic       clk,
  input  logic       line_in,   // Bridge tx.
  input  logic [1:0] fault,     // 0 none, 1 bad parity, 2 bad stop, 3 silent.
  output logic       line_out,  // Bridge rx.
  output logic [7:0] frame_byte,
  output logic       frame_par_ok,
  output logic       frame_stop_ok,
  output int         frame_cnt
);

  localparam logic [1:0] FAULT_PARITY = 2'd1;
  localparam logic [1:0] FAULT_STOP   = 2'd2;
  localparam logic [1:0] FAULT_SILENT = 2'd3;

  logic [7:0] regs [128];
  logic       wr_pend;
  logic [6:0] wr_addr;

  task automatic recv_frame();
    logic [7:0] b;
    int i;
    @(negedge line_in);
    repeat (clks_per_bit / 2) @(posedge clk);  // Middle of the start bit.
    for (i = 0; i < 8; i++)
    begin
      repeat (clks_per_bit) @(posedge clk);
      b[i] = line_in;
    end
    frame_byte = b;
    repeat (clks_per_bit) @(posedge clk);
    frame_par_ok = (line_in == ^b);
    repeat (clks_per_bit) @(posedge clk);
    frame_stop_ok = line_in;
  endtask

  task automatic send_frame(input logic [7:0] b);
    logic [10:0] f;
    int i;
    f = {fault != FAULT_STOP, (^b) ^ (fault == FAULT_PARITY), b, 1'b0};
    for (i = 0; i < 11; i++)
    begin
      #2 line_out = f[i];
      repeat (clks_per_bit) @(posedge clk);
    end
    #2 line_out = 1'b1;
  endtask

  initial
  begin
    line_out = 1'b1;
    wr_pend  = 1'b0;
    foreach (regs[i])
      regs[i] = 8'h00;
    forever
    begin
      recv_frame();
      frame_cnt++;
      if (wr_pend)
      begin
        regs[wr_addr] = frame_byte;
        wr_pend       = 1'b0;
      end
      else if (frame_byte[7])
      begin
        wr_pend = 1'b1;  // Address of a write, data frame follows.
        wr_addr = frame_byte[6:0];
      end
      else if (fault != FAULT_SILENT)
      begin
        repeat (3 * clks_per_bit) @(posedge clk);  // Turnaround.
        send_frame(regs[frame_byte[6:0]]);
      end
    end
  end

endmodule

//--- test/tb_uart_host_bridge.sv
`timescale 1ns/1ps

module tb_uart_host_bridge;

  import uart_pkg::*;

  localparam int CPB     = 16;
  localparam int N_DIR   = 10;
  localparam int N_ENT   = N_DIR + 16;
  localparam int MAX_CYC = N_ENT * (2 * FRAME_BITS + RESP_TIMEOUT_BITS + 8) * CPB;

  localparam logic [1:0] F_NONE   = 2'd0;
  localparam logic [1:0] F_PARITY = 2'd1;
  localparam logic [1:0] F_STOP   = 2'd2;
  localparam logic [1:0] F_SILENT = 2'd3;

  logic              clk;
  logic              rst_n;
  logic [CMD_W-1:0]  cmd_in;
  logic              cmd_vld;
  logic              cmd_rdy;
  logic              rx;
  logic              tx;
  logic              read_vld;
  logic [DATA_W-1:0] read_data;
  rd_status_e        read_status;
  logic [1:0]        fault;
  logic [7:0]        frame_byte;
  logic              frame_par_ok;
  logic              frame_stop_ok;
  int                frame_cnt;

  logic [CMD_W-1:0]  tbl_cmd [N_ENT];
  logic [1:0]        tbl_fault [N_ENT];
  rd_status_e        tbl_status [N_ENT];
  logic [DATA_W-1:0] shadow [128];
  logic [DATA_W-1:0] exp_q [$];  // Frames due on tx, in order.
  int                val_err;
  int                prot_err;
  int                cyc;
  int unsigned       seed_v;

  uart_host_bridge #(
    .clks_per_bit (CPB)
  ) i_uart_host_bridge (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_in      (cmd_in),
    .cmd_vld     (cmd_vld),
    .cmd_rdy     (cmd_rdy),
    .rx          (rx),
    .tx          (tx),
    .read_vld    (read_vld),
    .read_data   (read_data),
    .read_status (read_status)
  );

  uart_dev_model #(
    .clks_per_bit (CPB)
  ) i_uart_dev_model (
    .clk           (clk),
    .line_in       (tx),
    .fault         (fault),
    .line_out      (rx),
    .frame_byte    (frame_byte),
    .frame_par_ok  (frame_par_ok),
    .frame_stop_ok (frame_stop_ok),
    .frame_cnt     (frame_cnt)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // **************************************************************************
  // Checks
  // **************************************************************************

  task automatic check_level(input logic got, input logic exp, input string what);
    if (got !== exp)
    begin
      val_err++;
      $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_frame(input logic [DATA_W-1:0] got, input logic par_ok,
                             input logic stop_ok, input logic [DATA_W-1:0] exp);
    if (got !== exp || par_ok !== 1'b1 || stop_ok !== 1'b1)
    begin
      val_err++;
      $display("ERR %0t: frame 0x%02h parity_ok %b stop_ok %b, expected 0x%02h",
               $time, got, par_ok, stop_ok, exp);
    end
  endtask

  task automatic check_read(input logic [DATA_W-1:0] got_d, input rd_status_e got_s,
                            input logic [DATA_W-1:0] exp_d, input rd_status_e exp_s,
                            input bit use_data);
    if (got_s !== exp_s || (use_data && got_d !== exp_d))
    begin
      val_err++;
      $display("ERR %0t: read 0x%02h status %0d, expected 0x%02h status %0d",
               $time, got_d, got_s, exp_d, exp_s);
    end
  endtask

  always @(frame_cnt)
  begin
    @(negedge clk);
    if (exp_q.size() == 0)
    begin
      prot_err++;
      $display("Frame 0x%02h showed up on tx when none was due.", frame_byte);
    end
    else
      check_frame(frame_byte, frame_par_ok, frame_stop_ok, exp_q.pop_front());
  end

  // **************************************************************************
  // Stimulus table
  // **************************************************************************

  task automatic fill_table();
    int k;
    logic [6:0] a;
    for (k = 0; k < N_ENT; k++)
    begin
      tbl_fault[k]  = F_NONE;
      tbl_status[k] = RD_OK;
    end
    tbl_cmd[0] = {1'b1, 7'h05, 8'ha5};
    tbl_cmd[1] = {1'b1, 7'h7f, 8'h3c};
    tbl_cmd[2] = {1'b1, 7'h00, 8'hff};
    tbl_cmd[3] = {1'b0, 7'h05, 8'h00};
    tbl_cmd[4] = {1'b0, 7'h7f, 8'h99};  // Data bits of a read are ignored.
    tbl_cmd[5] = {1'b0, 7'h12, 8'h00};  // Never written.
    tbl_cmd[6] = {1'b0, 7'h05, 8'h00};
    tbl_cmd[7] = {1'b0, 7'h7f, 8'h00};
    tbl_cmd[8] = {1'b0, 7'h00, 8'h00};
    tbl_cmd[9] = {1'b1, 7'h12, 8'h5a};
    tbl_fault[6] = F_PARITY;
    tbl_status[6] = RD_PARITY_ERR;
    tbl_fault[7] = F_STOP;
    tbl_status[7] = RD_FRAME_ERR;
    tbl_fault[8] = F_SILENT;
    tbl_status[8] = RD_TIMEOUT;
    for (k = 0; k < 8; k++)
    begin
      a = 7'($urandom_range(127));
      tbl_cmd[N_DIR + 2 * k]     = {1'b1, a, 8'($urandom_range(255))};
      tbl_cmd[N_DIR + 2 * k + 1] = {1'b0, a, 8'($urandom_range(255))};
    end
  endtask

  // A write does not wait for its end, so the next command is held while busy.
  task automatic run_entry(input int k);
    logic [CMD_W-1:0] cmd;
    logic [6:0]       addr;
    cmd     = tbl_cmd[k];
    addr    = cmd[CMD_W-2:DATA_W];
    fault   = tbl_fault[k];
    cmd_in  = cmd;
    cmd_vld = 1'b1;
    @(negedge clk);
    while (!cmd_rdy)
      @(negedge clk);
    @(posedge clk);
    #2;
    cmd_vld = 1'b0;
    exp_q.push_back({cmd[CMD_W-1], addr});
    if (cmd[CMD_W-1])
    begin
      exp_q.push_back(cmd[DATA_W-1:0]);
      shadow[addr] = cmd[DATA_W-1:0];
    end
    @(negedge clk);
    check_level(cmd_rdy, 1'b0, "cmd_rdy after acceptance");
    if (!cmd[CMD_W-1])
    begin
      while (!read_vld)
        @(negedge clk);
      check_level(cmd_rdy, 1'b0, "cmd_rdy with read_vld");
      check_read(read_data, read_status, shadow[addr], tbl_status[k],
                 tbl_status[k] != RD_TIMEOUT);
      @(negedge clk);
      check_level(cmd_rdy, 1'b1, "cmd_rdy after read_vld");
      check_level(read_vld, 1'b0, "read_vld one cycle after the pulse");
    end
    @(posedge clk);
    #2;
  endtask

  initial
  begin
    int k;
    seed_v = 32'h32c4cf0b;
    void'($urandom(seed_v));
    rst_n    = 1'b0;
    cmd_in   = '0;
    cmd_vld  = 1'b0;
    fault    = F_NONE;
    val_err  = 0;
    prot_err = 0;
    foreach (shadow[i])
      shadow[i] = 8'h00;
    fill_table();
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;
    check_level(cmd_rdy, 1'b1, "cmd_rdy after reset");
    check_level(tx, 1'b1, "tx after reset");
    check_level(read_vld, 1'b0, "read_vld after reset");
    for (k = 0; k < N_ENT; k++)
      run_entry(k);
    @(negedge clk);
    while (!cmd_rdy)
      @(negedge clk);
    if (exp_q.size() != 0)
    begin
      prot_err++;
      $display("%0d expected frames never appeared on tx.", exp_q.size());
    end
    $display("Errors: %0d wrong values, %0d other failures", val_err, prot_err);
    if (val_err + prot_err == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

  initial
  begin
    cyc = 0;
    while (cyc < MAX_CYC)
    begin
      @(posedge clk);
      cyc++;
    end
    $display("Timeout, the run did not finish within %0d cycles.", MAX_CYC);
    $display(">>> FAIL");
    $finish;
  end

endmodule

//--- files.f
logic/uart_pkg.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_cmd_ctrl.sv
logic/uart_host_bridge.sv
test/uart_dev_model.sv
test/tb_uart_host_bridge.sv
